//--- vu_pkg.sv
package vu_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Sizes

   localparam int NUM_LANES      = 4;
   localparam int NUM_VREGS      = 8;
   localparam int SLOTS_PER_VREG = 4;
   localparam int MAX_VL         = NUM_LANES * SLOTS_PER_VREG;
   localparam int DATA_W         = 32;
   localparam int RF_DEPTH       = NUM_VREGS * SLOTS_PER_VREG;

   ////////////////////////////////////////////////////////////////////////////
   // Data and address types

   typedef logic [DATA_W-1:0]                 data_t;
   typedef logic [$clog2(NUM_VREGS)-1:0]      vreg_t;
   typedef logic [$clog2(SLOTS_PER_VREG)-1:0] slot_t;
   typedef logic [$clog2(RF_DEPTH)-1:0]       rf_addr_t;   // {vreg, slot}
   typedef logic [$clog2(MAX_VL+1)-1:0]       vl_t;
   typedef logic [NUM_LANES-1:0]              lane_mask_t;
   typedef logic [NUM_LANES-1:0][DATA_W-1:0]  lane_data_t; // Element l in lane l
   typedef logic [4:0]                        imm_t;

   ////////////////////////////////////////////////////////////////////////////
   // Encodings

   // Arithmetic ops first, the ALU relies on that order
   typedef enum logic [2:0] {
      VOP_ADD     = 3'd0,
      VOP_SUB     = 3'd1,
      VOP_AND     = 3'd2,
      VOP_OR      = 3'd3,
      VOP_XOR     = 3'd4,
      VOP_SLIDEUP = 3'd5,
      VOP_SLIDEDN = 3'd6,
      VOP_STORE   = 3'd7
   } vop_e;

   typedef enum logic [1:0] {
      OP2_VEC    = 2'd0,
      OP2_SCALAR = 2'd1,
      OP2_IMM    = 2'd2
   } op2_sel_e;

   typedef enum logic [1:0] {
      WB_ALU   = 2'd0,
      WB_SLIDE = 2'd1,
      WB_LOAD  = 2'd2
   } wb_sel_e;

endpackage

//--- lane_ctrl_if.sv
`timescale 1ns/1ps

interface lane_ctrl_if;

   // Read stage
   vu_pkg::rf_addr_t   rd_addr1;
   vu_pkg::rf_addr_t   rd_addr2;

   // Execute stage
   vu_pkg::vop_e       alu_op;
   vu_pkg::op2_sel_e   op2_sel;
   vu_pkg::data_t      operand;    // Scalar or extended immediate
   logic               slide_up;   // 1 moves data toward higher lanes

   // Write stage
   vu_pkg::lane_mask_t wr_en;
   vu_pkg::rf_addr_t   wr_addr;
   vu_pkg::wb_sel_e    wb_sel;

   modport ctrl (
      output rd_addr1, rd_addr2,
      output alu_op, op2_sel, operand, slide_up,
      output wr_en, wr_addr, wb_sel
   );

   modport lane (
      input rd_addr1, rd_addr2,
      input alu_op, op2_sel, operand,
      input wr_en, wr_addr, wb_sel
   );

   modport ring (
      input slide_up
   );

endinterface

//--- lane_alu.sv
`timescale 1ns/1ps

module lane_alu (
   input  logic           clk_i,
   input  logic           rst_i,
   input  vu_pkg::vop_e   op_i,
   input  vu_pkg::data_t  a_i,
   input  vu_pkg::data_t  b_i,
   output vu_pkg::data_t  res_o
);

   vu_pkg::data_t res_d;
   vu_pkg::data_t res_q;
   logic          arith;

   assign arith = (op_i < vu_pkg::VOP_SLIDEUP);

   always_comb begin
      case (op_i)
         vu_pkg::VOP_ADD: res_d = a_i + b_i;   // Wraps at 32 bits
         vu_pkg::VOP_SUB: res_d = a_i - b_i;
         vu_pkg::VOP_AND: res_d = a_i & b_i;
         vu_pkg::VOP_OR:  res_d = a_i | b_i;
         vu_pkg::VOP_XOR: res_d = a_i ^ b_i;
         default:         res_d = a_i;         // Result not written back
      endcase
   end

   always_ff @(posedge clk_i) begin
      res_q <= res_d;
   end

   assign res_o = res_q;

   // Op may only leave the ALU group after it has been held long enough
   // for the last ALU result to pass the write stage
   a_no_op_clash : assert property (@(posedge clk_i) disable iff (!rst_i)
      !arith && $past(arith) |-> $past(op_i, 2) == $past(op_i))
      else $error("slide or store op while an ALU write is pending");

endmodule

//--- slide_network.sv
`timescale 1ns/1ps

module slide_network (
   input  logic                clk_i,
   input  logic                rst_i,
   input  vu_pkg::lane_data_t  lane_data_i,
   lane_ctrl_if.ring           ctrl_if,
   output vu_pkg::lane_data_t  lane_data_o
);

   localparam int NL = vu_pkg::NUM_LANES;

   vu_pkg::lane_data_t rot_d;
   vu_pkg::lane_data_t rot_q;

   ////////////////////////////////////////////////////////////////////////////
   // Ring rotation by one lane

   always_comb begin
      for (int l = 0; l < NL; l++) begin
         if (ctrl_if.slide_up) begin
            rot_d[l] = lane_data_i[(l + NL - 1) % NL];   // Lane 0 takes lane 3
         end else begin
            rot_d[l] = lane_data_i[(l + 1) % NL];        // Lane 3 takes lane 0
         end
      end
   end

   // Same latency as the ALU result
   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         rot_q <= '0;
      end else begin
         rot_q <= rot_d;
      end
   end

   assign lane_data_o = rot_q;

endmodule

//--- vector_lane.sv
`timescale 1ns/1ps

module vector_lane #(
   parameter int LANE = 0
) (
   input  logic           clk_i,
   input  logic           rst_i,
   input  vu_pkg::data_t  load_data_i,
   input  vu_pkg::data_t  slide_data_i,
   lane_ctrl_if.lane      ctrl_if,
   output vu_pkg::data_t  rd2_data_o,
   output vu_pkg::data_t  store_data_o
);

   vu_pkg::data_t rf_mem [vu_pkg::RF_DEPTH];

   vu_pkg::data_t rd1_q;
   vu_pkg::data_t rd2_q;
   vu_pkg::data_t store_q;
   vu_pkg::data_t alu_b;
   vu_pkg::data_t alu_res;
   vu_pkg::data_t wr_data;

   ////////////////////////////////////////////////////////////////////////////
   // Register file, two registered reads and one write

   always_ff @(posedge clk_i) begin
      rd1_q <= rf_mem[ctrl_if.rd_addr1];
      rd2_q <= rf_mem[ctrl_if.rd_addr2];
      if (ctrl_if.wr_en[LANE]) begin
         rf_mem[ctrl_if.wr_addr] <= wr_data;
      end
   end

   // Store data lines up with the ALU and ring outputs
   always_ff @(posedge clk_i) begin
      store_q <= rd2_q;
   end

   assign rd2_data_o   = rd2_q;
   assign store_data_o = store_q;

   // Second operand
   assign alu_b = (ctrl_if.op2_sel == vu_pkg::OP2_VEC) ? rd2_q : ctrl_if.operand;

   lane_alu u_alu (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .op_i  (ctrl_if.alu_op),
      .a_i   (rd1_q),
      .b_i   (alu_b),
      .res_o (alu_res)
   );

   always_comb begin
      case (ctrl_if.wb_sel)
         vu_pkg::WB_SLIDE: wr_data = slide_data_i;
         vu_pkg::WB_LOAD:  wr_data = load_data_i;
         default:          wr_data = alu_res;
      endcase
   end

endmodule

//--- issue_ctrl.sv
`timescale 1ns/1ps

module issue_ctrl (
   input  logic               clk_i,
   input  logic               rst_i,
   input  logic               start_i,
   input  vu_pkg::vop_e       vop_i,
   input  vu_pkg::vreg_t      vd_i,
   input  vu_pkg::vreg_t      vs1_i,
   input  vu_pkg::vreg_t      vs2_i,
   input  vu_pkg::op2_sel_e   op2_sel_i,
   input  vu_pkg::data_t      scalar_i,
   input  vu_pkg::imm_t       imm_i,
   input  vu_pkg::vl_t        vl_i,
   input  logic               load_valid_i,
   input  vu_pkg::vreg_t      load_vreg_i,
   input  vu_pkg::slot_t      load_slot_i,
   output logic               ready_o,
   output logic               store_valid_o,
   output vu_pkg::lane_mask_t store_lane_valid_o,
   lane_ctrl_if.ctrl          ctrl_if
);

   // One slot in flight
   typedef struct packed {
      logic               valid;
      vu_pkg::vop_e       op;
      vu_pkg::slot_t      slot;
      vu_pkg::lane_mask_t mask;
   } stage_t;

   // Lane l of a slot holds element slot*4 + l
   function automatic vu_pkg::lane_mask_t tail_mask(vu_pkg::vl_t vl, vu_pkg::slot_t slot);
      vu_pkg::lane_mask_t m;
      for (int l = 0; l < vu_pkg::NUM_LANES; l++) begin
         m[l] = ({slot, 2'(l)} < vl);
      end
      return m;
   endfunction

   stage_t             s0_q, s1_q, s2_q;   // Read, execute, write
   logic [2:0]         n_in, n_q, slot_q, cnt_q;
   logic               accept, issue, load_ok;
   vu_pkg::vop_e       op_q, iss_op;
   vu_pkg::vreg_t      vd_q, vs1_q, vs2_q;
   vu_pkg::vl_t        vl_q, iss_vl;
   vu_pkg::slot_t      iss_slot;
   vu_pkg::op2_sel_e   op2_sel_q;
   vu_pkg::data_t      operand_d, operand_q;
   logic               slide_up_q;

   assign n_in    = 3'((vl_i + 6'd3) >> 2);   // Slot count, ceil(vl/4)
   assign ready_o = (cnt_q == '0);
   assign accept  = start_i && ready_o && (n_in != '0);
   assign issue   = accept || (slot_q < n_q);
   assign load_ok = load_valid_i && ready_o && !start_i;

   assign iss_op   = accept ? vop_i : op_q;
   assign iss_vl   = accept ? vl_i : vl_q;
   assign iss_slot = accept ? '0 : slot_q[1:0];

   always_comb begin
      case (op2_sel_i)
         vu_pkg::OP2_IMM: operand_d = {{(vu_pkg::DATA_W-$bits(imm_i)){imm_i[4]}}, imm_i};
         default:         operand_d = scalar_i;
      endcase
   end

   // Instruction fields, held until the next accept
   always_ff @(posedge clk_i) begin
      if (accept) begin
         op_q       <= vop_i;
         vd_q       <= vd_i;
         vs1_q      <= vs1_i;
         vs2_q      <= vs2_i;
         vl_q       <= vl_i;
         op2_sel_q  <= op2_sel_i;
         operand_q  <= operand_d;
         slide_up_q <= (vop_i == vu_pkg::VOP_SLIDEUP);
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Slot sequencing and delay line

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         n_q    <= '0;
         slot_q <= '0;
         cnt_q  <= '0;
         s0_q   <= '0;
         s1_q   <= '0;
         s2_q   <= '0;
      end else begin
         if (accept) begin
            n_q    <= n_in;
            slot_q <= 3'd1;
            cnt_q  <= n_in + 3'd3;   // Issue plus three stages of drain
         end else begin
            if (issue) slot_q <= slot_q + 3'd1;
            if (cnt_q != '0) cnt_q <= cnt_q - 3'd1;
         end
         s0_q.valid <= issue;
         if (issue) begin
            s0_q.op   <= iss_op;
            s0_q.slot <= iss_slot;
            s0_q.mask <= tail_mask(iss_vl, iss_slot);
         end
         s1_q <= s0_q;
         s2_q <= s1_q;
      end
   end

   assign ctrl_if.rd_addr1 = {vs1_q, s0_q.slot};
   assign ctrl_if.rd_addr2 = {vs2_q, s0_q.slot};
   assign ctrl_if.alu_op   = s1_q.op;
   assign ctrl_if.op2_sel  = op2_sel_q;
   assign ctrl_if.operand  = operand_q;
   assign ctrl_if.slide_up = slide_up_q;

   assign store_valid_o      = s2_q.valid && (s2_q.op == vu_pkg::VOP_STORE);
   assign store_lane_valid_o = store_valid_o ? s2_q.mask : '0;

   // Write port, pipeline first, loads only while idle
   always_comb begin
      if (s2_q.valid) begin
         ctrl_if.wr_en   = (s2_q.op == vu_pkg::VOP_STORE) ? '0 : s2_q.mask;
         ctrl_if.wr_addr = {vd_q, s2_q.slot};
         ctrl_if.wb_sel  = (s2_q.op inside {vu_pkg::VOP_SLIDEUP, vu_pkg::VOP_SLIDEDN}) ?
                           vu_pkg::WB_SLIDE : vu_pkg::WB_ALU;
      end else begin
         ctrl_if.wr_en   = {vu_pkg::NUM_LANES{load_ok}};
         ctrl_if.wr_addr = {load_vreg_i, load_slot_i};
         ctrl_if.wb_sel  = vu_pkg::WB_LOAD;
      end
   end

   a_start_idle : assert property (@(posedge clk_i) disable iff (!rst_i)
      start_i |-> ready_o)
      else $error("start_i while the unit is busy");

   a_load_idle : assert property (@(posedge clk_i) disable iff (!rst_i)
      load_valid_i |-> ready_o && !start_i)
      else $error("load_valid_i while busy or with start_i");

endmodule

//--- vector_unit.sv
`timescale 1ns/1ps

module vector_unit (
   input  logic                 clk_i,
   input  logic                 rst_i,

   // Instruction
   input  logic                 start_i,
   input  vu_pkg::vop_e         vop_i,
   input  vu_pkg::vreg_t        vd_i,
   input  vu_pkg::vreg_t        vs1_i,
   input  vu_pkg::vreg_t        vs2_i,
   input  vu_pkg::op2_sel_e     op2_sel_i,
   input  vu_pkg::data_t        scalar_i,
   input  vu_pkg::imm_t         imm_i,
   input  vu_pkg::vl_t          vl_i,
   output logic                 ready_o,

   // Direct load, one slot of one register in all lanes
   input  logic                 load_valid_i,
   input  vu_pkg::vreg_t        load_vreg_i,
   input  vu_pkg::slot_t        load_slot_i,
   input  vu_pkg::lane_data_t   load_data_i,

   // Store stream
   output logic                 store_valid_o,
   output vu_pkg::lane_mask_t   store_lane_valid_o,
   output vu_pkg::lane_data_t   store_data_o
);

   lane_ctrl_if ctrl_bus ();

   vu_pkg::lane_data_t rd2_data;     // Lanes to ring
   vu_pkg::lane_data_t slide_data;   // Ring back to lanes

   issue_ctrl u_issue (
      .clk_i              (clk_i),
      .rst_i              (rst_i),
      .start_i            (start_i),
      .vop_i              (vop_i),
      .vd_i               (vd_i),
      .vs1_i              (vs1_i),
      .vs2_i              (vs2_i),
      .op2_sel_i          (op2_sel_i),
      .scalar_i           (scalar_i),
      .imm_i              (imm_i),
      .vl_i               (vl_i),
      .load_valid_i       (load_valid_i),
      .load_vreg_i        (load_vreg_i),
      .load_slot_i        (load_slot_i),
      .ready_o            (ready_o),
      .store_valid_o      (store_valid_o),
      .store_lane_valid_o (store_lane_valid_o),
      .ctrl_if            (ctrl_bus.ctrl)
   );

   for (genvar l = 0; l < vu_pkg::NUM_LANES; l++) begin : g_lane
      vector_lane #(
         .LANE (l)
      ) u_lane (
         .clk_i        (clk_i),
         .rst_i        (rst_i),
         .load_data_i  (load_data_i[l]),
         .slide_data_i (slide_data[l]),
         .ctrl_if      (ctrl_bus.lane),
         .rd2_data_o   (rd2_data[l]),
         .store_data_o (store_data_o[l])
      );
   end

   slide_network u_slide (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .lane_data_i (rd2_data),
      .ctrl_if     (ctrl_bus.ring),
      .lane_data_o (slide_data)
   );

endmodule

//--- tb_vector_unit.sv
`timescale 1ns/1ps

module tb_vector_unit;

   localparam int NL     = vu_pkg::NUM_LANES;
   localparam int NS     = vu_pkg::SLOTS_PER_VREG;
   localparam int VL_MAX = vu_pkg::MAX_VL;

   // Run limit from the test lengths
   localparam int RESET_CYCLES = 4;
   localparam int LOAD_COUNT   = 8;
   localparam int INSTR_COUNT  = 62;
   localparam int INSTR_CYCLES = NS + 4;   // Accept edge plus N+3 busy
   localparam int MARGIN       = 100;
   localparam int MAX_CYCLES   = RESET_CYCLES + LOAD_COUNT + INSTR_COUNT * INSTR_CYCLES
                                 + MARGIN;

   logic                clk_i;
   logic                rst_i;
   logic                start_i;
   vu_pkg::vop_e        vop_i;
   vu_pkg::vreg_t       vd_i;
   vu_pkg::vreg_t       vs1_i;
   vu_pkg::vreg_t       vs2_i;
   vu_pkg::op2_sel_e    op2_sel_i;
   vu_pkg::data_t       scalar_i;
   vu_pkg::imm_t        imm_i;
   vu_pkg::vl_t         vl_i;
   logic                ready_o;
   logic                load_valid_i;
   vu_pkg::vreg_t       load_vreg_i;
   vu_pkg::slot_t       load_slot_i;
   vu_pkg::lane_data_t  load_data_i;
   logic                store_valid_o;
   vu_pkg::lane_mask_t  store_lane_valid_o;
   vu_pkg::lane_data_t  store_data_o;

   vu_pkg::data_t       model [vu_pkg::NUM_VREGS][VL_MAX];   // Element e at index e
   vu_pkg::lane_data_t  exp_data_q [$];
   vu_pkg::lane_mask_t  exp_mask_q [$];
   vu_pkg::lane_data_t  exp_data;
   vu_pkg::lane_mask_t  exp_mask;
   logic [31:0]         lfsr_state;
   int                  errors;
   int                  cycle_cnt;
   int                  test_num;
   int                  test_errs;
   int                  tail_vl [3] = '{6, 9, 0};

   vector_unit dut0 (.*);

   always #5 clk_i = ~clk_i;

   ////////////////////////////////////////////////////////////////////////////
   // Helpers

   function automatic logic [31:0] galois_step(logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   function automatic vu_pkg::data_t rand_word();
      vu_pkg::data_t w;
      w = '0;
      for (int b = 0; b < vu_pkg::DATA_W; b++) begin
         lfsr_state = galois_step(lfsr_state);
         w = {w[vu_pkg::DATA_W-2:0], lfsr_state[0]};   // One step per bit
      end
      return w;
   endfunction

   function automatic vu_pkg::lane_data_t keep_lanes(vu_pkg::lane_data_t d,
                                                      vu_pkg::lane_mask_t m);
      vu_pkg::lane_data_t r;
      for (int l = 0; l < NL; l++) begin
         r[l] = m[l] ? d[l] : '0;
      end
      return r;
   endfunction

   function automatic vu_pkg::data_t ref_alu(vu_pkg::vop_e op, vu_pkg::data_t a,
                                              vu_pkg::data_t b);
      case (op)
         vu_pkg::VOP_ADD: return a + b;
         vu_pkg::VOP_SUB: return a - b;
         vu_pkg::VOP_AND: return a & b;
         vu_pkg::VOP_OR:  return a | b;
         default:         return a ^ b;
      endcase
   endfunction

   // Reference update at accept with store slots queued in order
   task automatic apply_model(vu_pkg::vop_e op, int vd, int vs1, int vs2,
                              vu_pkg::op2_sel_e sel, vu_pkg::data_t scalar,
                              vu_pkg::imm_t imm, int vl);
      vu_pkg::data_t      src [VL_MAX];
      vu_pkg::data_t      b;
      vu_pkg::lane_data_t sd;
      vu_pkg::lane_mask_t sm;
      int                 lane;
      int                 base;
      for (int e = 0; e < VL_MAX; e++) begin
         src[e] = model[vs2][e];
      end
      if (op == vu_pkg::VOP_STORE) begin
         for (int s = 0; s < (vl + NL - 1) / NL; s++) begin
            for (int l = 0; l < NL; l++) begin
               sm[l] = ((s * NL + l) < vl);
               sd[l] = sm[l] ? src[s * NL + l] : '0;
            end
            exp_data_q.push_back(sd);
            exp_mask_q.push_back(sm);
         end
      end else begin
         for (int e = 0; e < vl; e++) begin
            lane = e % NL;
            base = e - lane;
            case (op)
               vu_pkg::VOP_SLIDEUP: model[vd][e] = src[base + (lane + NL - 1) % NL];
               vu_pkg::VOP_SLIDEDN: model[vd][e] = src[base + (lane + 1) % NL];
               default: begin
                  if (sel == vu_pkg::OP2_VEC) b = src[e];
                  else if (sel == vu_pkg::OP2_IMM) b = imm[4] ? 32'(imm) - 32'd32 : 32'(imm);
                  else b = scalar;
                  model[vd][e] = ref_alu(op, model[vs1][e], b);
               end
            endcase
         end
      end
   endtask

   // Called and returns at a falling edge with ready_o high
   task automatic issue_instr(vu_pkg::vop_e op, int vd, int vs1, int vs2,
                              vu_pkg::op2_sel_e sel, vu_pkg::data_t scalar,
                              vu_pkg::imm_t imm, int vl);
      int n;
      int busy;
      n         = (vl + NL - 1) / NL;
      vop_i     = op;
      vd_i      = vu_pkg::vreg_t'(vd);
      vs1_i     = vu_pkg::vreg_t'(vs1);
      vs2_i     = vu_pkg::vreg_t'(vs2);
      op2_sel_i = sel;
      scalar_i  = scalar;
      imm_i     = imm;
      vl_i      = vu_pkg::vl_t'(vl);
      start_i   = 1'b1;
      apply_model(op, vd, vs1, vs2, sel, scalar, imm, vl);
      @(posedge clk_i);
      @(negedge clk_i);
      start_i = 1'b0;
      busy    = 0;
      while (!ready_o) begin
         busy++;
         @(negedge clk_i);
      end
      assert (busy == ((n == 0) ? 0 : n + 3)) else begin
         $display("Error ready_o low cycles: got %h, expected %h", busy,
                  (n == 0) ? 0 : n + 3);
         errors++;
      end
   endtask

   task automatic store_reg(int vs, int vl);
      issue_instr(vu_pkg::VOP_STORE, 0, 0, vs, vu_pkg::OP2_VEC, '0, '0, vl);
   endtask

   task automatic load_reg(int r);
      vu_pkg::lane_data_t d;
      for (int s = 0; s < NS; s++) begin
         for (int l = 0; l < NL; l++) begin
            d[l]               = rand_word();
            model[r][s*NL + l] = d[l];
         end
         load_valid_i = 1'b1;
         load_vreg_i  = vu_pkg::vreg_t'(r);
         load_slot_i  = vu_pkg::slot_t'(s);
         load_data_i  = d;
         @(negedge clk_i);
         load_valid_i = 1'b0;
      end
   endtask

   task automatic report_test(string name);
      test_num++;
      $display("Test %0d %s: %0d errors", test_num, name, errors - test_errs);
      test_errs = errors;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Store checks

   // Next expected slot is stable for the following rising edge
   always @(negedge clk_i) begin
      if (rst_i && store_valid_o) begin
         if (exp_data_q.size() == 0) begin
            $display("A store slot appeared with no store slot expected");
            errors++;
         end else begin
            exp_data = exp_data_q.pop_front();
            exp_mask = exp_mask_q.pop_front();
         end
      end
   end

   a_store_data : assert property (@(posedge clk_i) disable iff (!rst_i)
      store_valid_o |-> keep_lanes(store_data_o, exp_mask) == exp_data)
      else begin
         $display("Error store_data_o: got %h, expected %h",
                  keep_lanes($sampled(store_data_o), $sampled(exp_mask)), $sampled(exp_data));
         errors++;
      end

   a_store_mask : assert property (@(posedge clk_i) disable iff (!rst_i)
      store_valid_o |-> store_lane_valid_o == exp_mask)
      else begin
         $display("Error store_lane_valid_o: got %h, expected %h",
                  $sampled(store_lane_valid_o), $sampled(exp_mask));
         errors++;
      end

   a_mask_idle : assert property (@(posedge clk_i) disable iff (!rst_i)
      !store_valid_o |-> store_lane_valid_o == '0)
      else begin
         $display("Error store_lane_valid_o: got %h, expected 0", $sampled(store_lane_valid_o));
         errors++;
      end

   always @(posedge clk_i) begin
      cycle_cnt++;
      if (cycle_cnt >= MAX_CYCLES) begin
         $display("Timeout after %0d cycles, the run did not complete", cycle_cnt);
         $display("Done: errors found");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus

   initial begin
      clk_i        = 1'b0;
      rst_i        = 1'b0;
      start_i      = 1'b0;
      vop_i        = vu_pkg::VOP_ADD;
      vd_i         = '0;
      vs1_i        = '0;
      vs2_i        = '0;
      op2_sel_i    = vu_pkg::OP2_VEC;
      scalar_i     = '0;
      imm_i        = '0;
      vl_i         = '0;
      load_valid_i = 1'b0;
      load_vreg_i  = '0;
      load_slot_i  = '0;
      load_data_i  = '0;
      lfsr_state   = 32'hc0ca;
      errors       = 0;
      cycle_cnt    = 0;
      test_num     = 0;
      test_errs    = 0;
      exp_data     = '0;
      exp_mask     = '0;
      for (int r = 0; r < vu_pkg::NUM_VREGS; r++) begin
         for (int e = 0; e < VL_MAX; e++) begin
            model[r][e] = '0;
         end
      end
      repeat (RESET_CYCLES) @(negedge clk_i);
      rst_i = 1'b1;

      assert (ready_o == 1'b1) else begin
         $display("Error ready_o after reset: got %h, expected 1", ready_o);
         errors++;
      end
      assert (store_valid_o == 1'b0) else begin
         $display("Error store_valid_o after reset: got %h, expected 0", store_valid_o);
         errors++;
      end
      load_reg(1);
      load_reg(2);
      store_reg(1, VL_MAX);
      store_reg(2, VL_MAX);
      report_test("load and store");

      for (int i = 0; i < 5; i++) begin
         issue_instr(vu_pkg::vop_e'(i), 3, 1, 2, vu_pkg::OP2_VEC, '0, '0, VL_MAX);
         store_reg(3, VL_MAX);
      end
      report_test("vector operand");

      for (int i = 0; i < 5; i++) begin
         issue_instr(vu_pkg::vop_e'(i), 3, 1, 0, vu_pkg::OP2_SCALAR, rand_word(), '0, VL_MAX);
         store_reg(3, VL_MAX);
         issue_instr(vu_pkg::vop_e'(i), 4, 2, 0, vu_pkg::OP2_IMM, '0, 5'h19, VL_MAX);  // -7
         store_reg(4, VL_MAX);
         issue_instr(vu_pkg::vop_e'(i), 4, 1, 0, vu_pkg::OP2_IMM, '0, 5'h0b, VL_MAX);  // +11
         store_reg(4, VL_MAX);
      end
      report_test("scalar and immediate");

      foreach (tail_vl[i]) begin
         issue_instr(vu_pkg::VOP_ADD, 3, 1, 2, vu_pkg::OP2_VEC, '0, '0, tail_vl[i]);
         store_reg(3, VL_MAX);
         store_reg(3, tail_vl[i]);
      end
      report_test("tail");

      issue_instr(vu_pkg::VOP_SLIDEUP, 5, 0, 1, vu_pkg::OP2_VEC, '0, '0, VL_MAX);
      store_reg(5, VL_MAX);
      issue_instr(vu_pkg::VOP_SLIDEDN, 6, 0, 2, vu_pkg::OP2_VEC, '0, '0, VL_MAX);
      store_reg(6, VL_MAX);
      issue_instr(vu_pkg::VOP_SLIDEUP, 5, 0, 5, vu_pkg::OP2_VEC, '0, '0, VL_MAX);  // In place
      store_reg(5, VL_MAX);
      report_test("slides");

      // Each one reads the previous destination
      issue_instr(vu_pkg::VOP_ADD, 7, 1, 2, vu_pkg::OP2_VEC, '0, '0, VL_MAX);
      issue_instr(vu_pkg::VOP_XOR, 7, 7, 1, vu_pkg::OP2_VEC, '0, '0, VL_MAX);
      issue_instr(vu_pkg::VOP_SUB, 7, 7, 0, vu_pkg::OP2_SCALAR, rand_word(), '0, VL_MAX);
      issue_instr(vu_pkg::VOP_SLIDEUP, 6, 0, 7, vu_pkg::OP2_VEC, '0, '0, VL_MAX);
      store_reg(6, VL_MAX);
      report_test("back to back");

      repeat (4) @(negedge clk_i);
      assert (exp_data_q.size() == 0) else begin
         $display("%0d expected store slots never appeared", exp_data_q.size());
         errors++;
      end

      $display("Summary: %0d tests, %0d errors", test_num, errors);
      if (errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

//--- list.f
vu_pkg.sv
lane_ctrl_if.sv
lane_alu.sv
slide_network.sv
vector_lane.sv
issue_ctrl.sv
vector_unit.sv
tb_vector_unit.sv

//--- run.sh
#!/bin/sh
# Build and run the vector unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_vector_unit \
   -f list.f -o tb_vector_unit
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/tb_vector_unit)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx "Done: no errors"; then
   exit 0
fi
exit 1
